// ==== blaster_capture.f ====
+incdir+hw
hw/capture_pkg.sv
hw/wb_if.sv
hw/sample_fifo.sv
hw/frame_packer.sv
hw/burst_writer.sv
hw/wb_arbiter.sv
hw/sample_ram.sv
hw/blaster_capture.sv
tests/tb_blaster_capture.sv

// ==== hw/blaster_capture.sv ====
`timescale 1ns/10ps
`include "capture_settings.svh"

module blaster_capture import capture_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	// Converter frame
	input  logic      ad_strobe,
	input  sample_t   ad_a0,
	input  sample_t   ad_a1,
	input  sample_t   ad_b0,
	input  sample_t   ad_b1,
	input  logic      pwm,
	// Host read port
	input  logic      host_cyc,
	input  mem_addr_t host_adr,
	output logic      host_ack,
	output mem_word_t host_dat,
	// Capture status
	output mem_addr_t write_addr,
	output mem_addr_t trigger_addr,
	output logic      trigger_valid
);

	logic                                fifo_push;
	fifo_word_t                          fifo_push_data;
	logic                                fifo_pop;
	fifo_word_t                          fifo_pop_data;
	logic [$clog2(`FIFO_DEPTH+1)-1:0]    fifo_count;

	wb_if writer_bus ();
	wb_if ram_bus ();

	////////////////////////////////////////////////////
	// Capture path
	////////////////////////////////////////////////////
	frame_packer frame_packer_inst (
		.clk(clk), .reset(reset), .ad_strobe(ad_strobe), .pwm(pwm),
		.ad_a0(ad_a0), .ad_a1(ad_a1), .ad_b0(ad_b0), .ad_b1(ad_b1),
		.fifo_push(fifo_push), .fifo_data(fifo_push_data)
	);

	sample_fifo #(.payload_t(fifo_word_t), .DEPTH(`FIFO_DEPTH)) sample_fifo_inst (
		.clk(clk), .reset(reset), .push(fifo_push), .push_data(fifo_push_data),
		.pop(fifo_pop), .pop_data(fifo_pop_data), .count(fifo_count)
	);

	burst_writer burst_writer_inst (
		.clk(clk), .reset(reset), .fifo_count(fifo_count), .fifo_pop(fifo_pop),
		.fifo_data(fifo_pop_data), .wb(writer_bus), .write_addr(write_addr),
		.trigger_addr(trigger_addr), .trigger_valid(trigger_valid)
	);

	// Shared memory, host and writer
	wb_arbiter wb_arbiter_inst (
		.clk(clk), .reset(reset), .writer(writer_bus), .host_cyc(host_cyc),
		.host_adr(host_adr), .host_ack(host_ack), .host_dat(host_dat), .ram(ram_bus)
	);

	sample_ram sample_ram_inst (
		.clk(clk), .bus(ram_bus)
	);

	// Whole frame must fit when its strobe arrives
	a_fifo_room: assert property (@(posedge clk) disable iff (reset)
		ad_strobe |-> fifo_count <= (`FIFO_DEPTH - `FRAME_WORDS));

endmodule

// ==== hw/burst_writer.sv ====
`timescale 1ns/10ps
`include "capture_settings.svh"

module burst_writer import capture_pkg::*; (
	input  logic                               clk,
	input  logic                               reset,
	input  logic [$clog2(`FIFO_DEPTH+1)-1:0]   fifo_count,
	output logic                               fifo_pop,
	input  fifo_word_t                         fifo_data,
	wb_if.master                               wb,
	output mem_addr_t                          write_addr,
	output mem_addr_t                          trigger_addr,
	output logic                               trigger_valid
);

	typedef enum logic {IDLE, BURST} state_t;

	state_t                             state;
	logic [$clog2(`BURST_WORDS+1)-1:0]  words_left;
	logic                               cyc;
	logic                               stb;

	// Write only, data straight from the FIFO head
	assign wb.cyc   = cyc;
	assign wb.stb   = stb;
	assign wb.we    = 1'b1;
	assign wb.adr   = write_addr;
	assign wb.dat_w = fifo_data.word;

	// One pop per acknowledged word
	assign fifo_pop = stb && wb.ack;

	always_ff @(posedge clk) begin
		if (reset) begin
			state         <= IDLE;
			cyc           <= 1'b0;
			stb           <= 1'b0;
			words_left    <= '0;
			write_addr    <= '0;
			trigger_valid <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					// Whole burst already buffered
					if (fifo_count >= `BURST_WORDS) begin
						state      <= BURST;
						cyc        <= 1'b1;
						stb        <= 1'b1;
						words_left <= `BURST_WORDS;
					end
				end
				BURST: begin
					if (stb && wb.ack) begin
						stb        <= 1'b0;
						write_addr <= write_addr + 1'b1;
						words_left <= words_left - 1'b1;
						// Marked word goes to the view alignment
						if (fifo_data.mark && !trigger_valid) begin
							trigger_addr  <= write_addr - mem_addr_t'(`PRETRIG_WORDS);
							trigger_valid <= 1'b1;
						end
						if (words_left == 1) begin
							state <= IDLE;
							cyc   <= 1'b0;
						end
					end else if (!stb) begin
						// Next word of the burst
						stb <= 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// ==== hw/capture_pkg.sv ====
`include "capture_settings.svh"

package capture_pkg;

	// One converter sample
	typedef logic [`SAMPLE_BITS-1:0] sample_t;

	// Sample memory word
	typedef logic [`WORD_BITS-1:0] mem_word_t;

	// Word address into the sample memory
	typedef logic [`MEM_ADDR_BITS-1:0] mem_addr_t;

	// FIFO entry
	// mark flags word 0 of the trigger frame
	typedef struct packed {
		logic      mark;
		mem_word_t word;
	} fifo_word_t;

endpackage

// ==== hw/capture_settings.svh ====
`ifndef CAPTURE_SETTINGS_SVH
`define CAPTURE_SETTINGS_SVH

// Converter sample width
`define SAMPLE_BITS 12

// Memory word and address widths
`define WORD_BITS 16
`define MEM_ADDR_BITS 8

// Words between packer and burst writer
`define FIFO_DEPTH 16

// Words per memory write burst
`define BURST_WORDS 8

// One frame is a0, a1, b0, b1
`define FRAME_WORDS 4

// View start ahead of the pwm rise, in words
`define PRETRIG_WORDS 16

// Word 3 carries the pwm flag here
`define PWM_BIT 12

`endif

// ==== hw/frame_packer.sv ====
`timescale 1ns/10ps
`include "capture_settings.svh"

module frame_packer import capture_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       ad_strobe,
	input  logic       pwm,
	input  sample_t    ad_a0,
	input  sample_t    ad_a1,
	input  sample_t    ad_b0,
	input  sample_t    ad_b1,
	output logic       fifo_push,
	output fifo_word_t fifo_data
);

	// Delayed strobes select words 1 to 3
	logic [`FRAME_WORDS-2:0] strobe_d;
	sample_t                 a1_q, b0_q, b1_q;
	// pwm of the latest frame, also the previous one at the next strobe
	logic                    pwm_last;
	logic                    trig_done;
	logic                    trig_now;

	// First rising pwm frame since reset
	assign trig_now = pwm && !pwm_last && !trig_done;

	always_ff @(posedge clk) begin
		if (reset) begin
			strobe_d  <= '0;
			pwm_last  <= 1'b0;
			trig_done <= 1'b0;
		end else begin
			strobe_d <= {strobe_d[`FRAME_WORDS-3:0], ad_strobe};
			if (ad_strobe) begin
				pwm_last <= pwm;
				if (trig_now) begin
					trig_done <= 1'b1;
				end
			end
		end
	end

	// Held samples, a0 goes out directly
	always_ff @(posedge clk) begin
		if (ad_strobe) begin
			a1_q <= ad_a1;
			b0_q <= ad_b0;
			b1_q <= ad_b1;
		end
	end

	////////////////////////////////////////////////////
	// Word select, upper bits zero
	////////////////////////////////////////////////////
	always_comb begin
		fifo_data = '0;
		if (ad_strobe) begin
			fifo_data.mark = trig_now;
			fifo_data.word = mem_word_t'(ad_a0);
		end else if (strobe_d[0]) begin
			fifo_data.word = mem_word_t'(a1_q);
		end else if (strobe_d[1]) begin
			fifo_data.word = mem_word_t'(b0_q);
		end else if (strobe_d[2]) begin
			fifo_data.word = mem_word_t'(b1_q);
			fifo_data.word[`PWM_BIT] = pwm_last;
		end
	end

	assign fifo_push = ad_strobe | (|strobe_d);

	// Next frame must not cut into the current one
	a_strobe_gap: assert property (@(posedge clk) disable iff (reset)
		ad_strobe |=> (!ad_strobe) [* (`FRAME_WORDS - 1)]);

endmodule

// ==== hw/sample_fifo.sv ====
`timescale 1ns/10ps
`include "capture_settings.svh"

module sample_fifo #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = `FIFO_DEPTH
) (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         push,
	input  payload_t                     push_data,
	input  logic                         pop,
	output payload_t                     pop_data,
	output logic [$clog2(DEPTH+1)-1:0]   count
);

	localparam int PTR_BITS = $clog2(DEPTH);

	payload_t            mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;

	// Storage, written on push only
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// Head of queue, valid whenever count is nonzero
	assign pop_data = mem[rd_ptr];

	// Pointers and occupancy
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Overrun would lose a word silently
	a_no_push_full: assert property (@(posedge clk) disable iff (reset)
		push |-> (count != DEPTH) || pop);

	// Underrun would hand out stale data
	a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
		pop |-> count != 0);

endmodule

// ==== hw/sample_ram.sv ====
`timescale 1ns/10ps

module sample_ram import capture_pkg::*; (
	input logic clk,
	wb_if.slave bus
);

	localparam int WORDS = 1 << $bits(mem_addr_t);

	mem_word_t mem [WORDS];
	logic      req;

	// New request, the ack cycle itself is not one
	assign req = bus.cyc && bus.stb && !bus.ack;

	// Single write per transfer
	always_ff @(posedge clk) begin
		if (req && bus.we) begin
			mem[bus.adr] <= bus.dat_w;
		end
	end

	// Read data lines up with ack
	always_ff @(posedge clk) begin
		bus.dat_r <= mem[bus.adr];
	end

	// One cycle after strobe, never back to back
	// Idle bus during reset clears it
	always_ff @(posedge clk) begin
		bus.ack <= req;
	end

endmodule

// ==== hw/wb_arbiter.sv ====
`timescale 1ns/10ps

module wb_arbiter import capture_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	wb_if.slave       writer,
	input  logic      host_cyc,
	input  mem_addr_t host_adr,
	output logic      host_ack,
	output mem_word_t host_dat,
	wb_if.master      ram
);

	logic writer_req;
	logic host_req;
	logic pick_host;
	// Transfer in flight and who owns it
	logic busy;
	logic owner_host;
	// Round robin memory, 1 when the host went last
	logic last_host;
	logic grant_host;

	assign writer_req = writer.cyc && writer.stb;
	assign host_req   = host_cyc;

	// Host wins a tie only after a writer transfer
	assign pick_host  = host_req && (!writer_req || !last_host);
	assign grant_host = busy ? owner_host : pick_host;

	////////////////////////////////////////////////////
	// Steering onto the RAM link, no added cycle
	////////////////////////////////////////////////////
	assign ram.cyc   = grant_host ? host_cyc : writer.cyc;
	assign ram.stb   = grant_host ? host_cyc : writer.stb;
	assign ram.we    = grant_host ? 1'b0 : writer.we;
	assign ram.adr   = grant_host ? host_adr : writer.adr;
	assign ram.dat_w = writer.dat_w;

	// Ack back to the owner only
	assign writer.ack   = ram.ack && !grant_host;
	assign writer.dat_r = ram.dat_r;
	assign host_ack     = ram.ack && grant_host;
	assign host_dat     = ram.dat_r;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy       <= 1'b0;
			owner_host <= 1'b0;
			last_host  <= 1'b1;
		end else if (ram.ack) begin
			// Grant released the cycle after ack
			busy      <= 1'b0;
			last_host <= grant_host;
		end else if (!busy && (writer_req || host_req)) begin
			busy       <= 1'b1;
			owner_host <= pick_host;
		end
	end

	// RAM ack only lands on a master holding the grant
	a_ack_granted: assert property (@(posedge clk) disable iff (reset)
		ram.ack |-> busy && (grant_host ? host_cyc : writer_req));

endmodule

// ==== hw/wb_if.sv ====
`timescale 1ns/10ps

// One Wishbone classic link, single word transfers
interface wb_if import capture_pkg::*; ();

	logic      cyc;
	logic      stb;
	logic      we;
	mem_addr_t adr;
	mem_word_t dat_w;
	mem_word_t dat_r;
	logic      ack;

	// Master holds cyc/stb until ack, drops stb the cycle after
	modport master (
		output cyc, stb, we, adr, dat_w,
		input  dat_r, ack
	);

	// One ack pulse per transfer
	modport slave (
		input  cyc, stb, we, adr, dat_w,
		output dat_r, ack
	);

endinterface

// ==== run_sim.sh ====
#!/bin/sh
# Build the capture path testbench with Verilator, run it, then judge the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	--top-module tb_blaster_capture \
	-f blaster_capture.f

# tee keeps the pipeline going so the log is always searched
./obj_dir/Vtb_blaster_capture | tee sim.log

if grep -qx "Test completed successfully" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi

// ==== tests/tb_blaster_capture.sv ====
`timescale 1ns/10ps
`include "capture_settings.svh"

module tb_blaster_capture import capture_pkg::*; ();

	localparam int CLK_PERIOD        = 100;
	localparam int STROBE_GAP        = 12;
	localparam int RANDOM_SEED       = 78;
	localparam int WAIT_CYCLES       = 2000;
	localparam int READ_CYCLES       = 32;
	localparam int LAYOUT_FRAMES     = 8;
	localparam int CONTENTION_FRAMES = 4;
	localparam int WRAP_FRAMES       = 80;
	localparam int FRAME_WORDS       = `FRAME_WORDS;
	localparam int MEM_WORDS         = 1 << `MEM_ADDR_BITS;

	// One sent frame with s[0] as a0
	typedef struct packed {
		logic                          pwm;
		sample_t [`FRAME_WORDS-1:0]    s;
	} frame_t;

	logic      clk;
	logic      reset;
	logic      ad_strobe;
	sample_t   ad_a0;
	sample_t   ad_a1;
	sample_t   ad_b0;
	sample_t   ad_b1;
	logic      pwm;
	logic      host_cyc;
	mem_addr_t host_adr;
	logic      host_ack;
	mem_word_t host_dat;
	mem_addr_t write_addr;
	mem_addr_t trigger_addr;
	logic      trigger_valid;

	// Every frame since the last reset in send order
	frame_t frames[$];
	int     reads_checked;
	// Reads that the host side saw acknowledged
	int     reads_issued;
	bit     streaming;

	blaster_capture blaster_capture_inst (
		.clk(clk), .reset(reset), .ad_strobe(ad_strobe),
		.ad_a0(ad_a0), .ad_a1(ad_a1), .ad_b0(ad_b0), .ad_b1(ad_b1), .pwm(pwm),
		.host_cyc(host_cyc), .host_adr(host_adr), .host_ack(host_ack), .host_dat(host_dat),
		.write_addr(write_addr), .trigger_addr(trigger_addr), .trigger_valid(trigger_valid)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	// Newest word that landed on addr
	// Sample in the low bits and pwm on word 3
	function automatic mem_word_t expected_word(input int unsigned addr);
		int unsigned n_words;
		int unsigned k;
		logic [1:0]  pos;
		frame_t      f;
		mem_word_t   w;
		n_words = FRAME_WORDS * frames.size();
		k = addr;
		while (k + MEM_WORDS < n_words) begin
			k = k + MEM_WORDS;
		end
		f = frames[k / FRAME_WORDS];
		pos = 2'(k % FRAME_WORDS);
		w = '0;
		w[`SAMPLE_BITS-1:0] = f.s[pos];
		if (pos == 2'd3) begin
			w[`PWM_BIT] = f.pwm;
		end
		return w;
	endfunction

	// View address of the first pwm rise or -1 if none
	function automatic int expected_trigger();
		logic prev;
		prev = 1'b0;
		for (int f = 0; f < frames.size(); f++) begin
			if (frames[f].pwm && !prev) begin
				return (f * FRAME_WORDS - `PRETRIG_WORDS + MEM_WORDS) % MEM_WORDS;
			end
			prev = frames[f].pwm;
		end
		return -1;
	endfunction

	//////////////////////////////////////////////////
	// Checks and waits
	//////////////////////////////////////////////////

	task automatic stop_run();
		$display("Test failed");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("Mismatch at %0t: %s, got %0h, expected %0h", $time, what, actual,
				expected);
			stop_run();
		end
	endtask

	// Every host read against the model
	always @(negedge clk) begin
		if (host_ack) begin
			reads_checked++;
			if (32'(host_adr) >= 32'(FRAME_WORDS * frames.size())) begin
				$display("Host read of address %0d, which holds no captured word", host_adr);
				stop_run();
			end else begin
				check_equal(32'(host_dat), 32'(expected_word(32'(host_adr))),
					$sformatf("host read at address %0d", host_adr));
			end
		end
	end

	// Every word sent so far has been written
	task automatic wait_all_written(input string what);
		mem_addr_t target;
		int        cycles;
		target = mem_addr_t'(FRAME_WORDS * frames.size());
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > WAIT_CYCLES) begin
				$display("Write address never reached %0d after %s", target, what);
				stop_run();
			end
		end while (write_addr !== target);
	endtask

	task automatic wait_trigger_valid();
		int cycles;
		cycles = 0;
		while (trigger_valid !== 1'b1) begin
			@(negedge clk);
			cycles++;
			if (cycles > WAIT_CYCLES) begin
				$display("Trigger valid never rose after the pwm rise");
				stop_run();
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	// Called right after a rising edge
	task automatic apply_reset();
		reset <= 1'b1;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
	endtask

	// One strobe then quiet until the next slot
	task automatic send_frame(input logic pwm_level);
		frame_t f;
		f.pwm = pwm_level;
		for (int i = 0; i < FRAME_WORDS; i++) begin
			f.s[i] = sample_t'($urandom);
		end
		@(posedge clk);
		ad_strobe <= 1'b1;
		ad_a0     <= f.s[0];
		ad_a1     <= f.s[1];
		ad_b0     <= f.s[2];
		ad_b1     <= f.s[3];
		pwm       <= pwm_level;
		frames.push_back(f);
		@(posedge clk);
		ad_strobe <= 1'b0;
		repeat (STROBE_GAP - 2) @(posedge clk);
	endtask

	// Read-only master that drops cyc the cycle after ack
	task automatic host_read(input mem_addr_t addr);
		int cycles;
		@(posedge clk);
		host_cyc <= 1'b1;
		host_adr <= addr;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > READ_CYCLES) begin
				$display("Host read of address %0d got no ack", addr);
				stop_run();
			end
		end while (host_ack !== 1'b1);
		reads_issued++;
		@(posedge clk);
		host_cyc <= 1'b0;
	endtask

	task automatic check_range(input int unsigned first, input int unsigned last);
		for (int unsigned a = first; a <= last; a++) begin
			host_read(mem_addr_t'(a));
		end
	endtask

	initial begin
		int expected_trig;
		void'($urandom(RANDOM_SEED));
		reads_checked = 0;
		reads_issued = 0;
		streaming = 1'b0;
		ad_strobe <= 1'b0;
		ad_a0     <= '0;
		ad_a1     <= '0;
		ad_b0     <= '0;
		ad_b1     <= '0;
		pwm       <= 1'b0;
		host_cyc  <= 1'b0;
		host_adr  <= '0;
		apply_reset();

		// Reset state
		@(negedge clk);
		check_equal(32'(write_addr), 32'd0, "write address after reset");
		check_equal(32'(trigger_valid), 32'd0, "trigger valid after reset");
		check_equal(32'(host_ack), 32'd0, "host ack after reset");

		// Layout with pwm low
		repeat (LAYOUT_FRAMES) send_frame(1'b0);
		wait_all_written("layout frames");
		check_range(0, FRAME_WORDS * LAYOUT_FRAMES - 1);

		// First pwm rise sets the view address
		repeat (4) send_frame(1'b0);
		repeat (4) send_frame(1'b1);
		wait_all_written("first pwm rise");
		wait_trigger_valid();
		expected_trig = expected_trigger();
		check_equal(32'(trigger_addr), 32'(expected_trig), "trigger address");

		// Second rise leaves it alone
		repeat (2) send_frame(1'b0);
		repeat (2) send_frame(1'b1);
		wait_all_written("second pwm rise");
		check_equal(32'(trigger_valid), 32'd1, "trigger valid held");
		check_equal(32'(trigger_addr), 32'(expected_trig), "trigger address after second rise");
		check_range(FRAME_WORDS * LAYOUT_FRAMES, FRAME_WORDS * frames.size() - 1);

		// Host reads while the writer bursts
		streaming = 1'b1;
		fork
			begin
				repeat (CONTENTION_FRAMES) send_frame(1'($urandom));
				streaming = 1'b0;
			end
			begin
				while (streaming) begin
					host_read(mem_addr_t'($urandom % 32'(write_addr)));
				end
			end
		join
		wait_all_written("frames under host contention");
		// One host ack per read and none without a read
		check_equal(32'(reads_checked), 32'(reads_issued), "host acks against host reads");

		// 320 words wrap into 256
		@(posedge clk);
		apply_reset();
		frames.delete();
		repeat (WRAP_FRAMES) send_frame(1'($urandom));
		wait_all_written("wrap frames");
		check_range(0, MEM_WORDS - 1);
		// No stray write after the last frame
		check_equal(32'(write_addr), 32'((FRAME_WORDS * WRAP_FRAMES) % MEM_WORDS),
			"write address after wrap");

		$display("Test completed successfully");
		$finish;
	end

endmodule
